//--- compile.f
logic/traceMonPkg.sv
logic/fetchCapture.sv
logic/instrDecode.sv
logic/traceFifo.sv
logic/apbRegs.sv
logic/cpuTraceMonitor.sv
dv/tbClockGen.sv
dv/traceMonitor_asserts.sv
dv/tbTraceMonitor.sv

//--- dv/tbTraceMonitor.sv
// ****************************************
// trace monitor testbench
// directed tests over the fetch, data and APB buses
// ****************************************
`timescale 1ns/1ps

module tbTraceMonitor;
   import traceMonPkg::*;

   // longest run is a few hundred cycles, limit gives plenty of margin
   localparam int CYCLE_LIMIT = 3000;

   logic       CLK;
   logic       RST_SYNC;
   instBusT    instBus;
   dataBusT    dataBus;
   apbReqT     apbReq;
   wordT       prdata;

   int         valueErrors = 0;
   int         otherErrors = 0;
   int         cycleCount = 0;
   logic [31:0] lcgState = 32'd10;

   // expected buffer contents, in order
   traceEntryT expQ[$];
   seqT        expSeq = '0;
   logic       expPrevCtrl = 1'b0;
   int         expLevel = 0;

   tbClockGen tbClockGen_inst
   (
      .CLK      (CLK),
      .RST_SYNC (RST_SYNC)
   );

   cpuTraceMonitor cpuTraceMonitor_inst
   (
      .CLK      (CLK),
      .RST_SYNC (RST_SYNC),
      .instBus  (instBus),
      .dataBus  (dataBus),
      .apbReq   (apbReq),
      .prdata   (prdata)
   );

   bind traceFifo traceMonitor_asserts traceMonitor_asserts_inst
   (
      .CLK      (CLK),
      .RST_SYNC (RST_SYNC),
      .level    (level),
      .overflow (overflow),
      .pop      (pop)
   );

   // ****************************************
   // helpers
   // ****************************************
   function automatic logic [31:0] nextRandom();
      lcgState = lcgState * 32'd1103515245 + 32'd12345;
      return lcgState;
   endfunction

   // inputs change 1 ns after the edge
   task automatic nextCycle();
      @(posedge CLK);
      #1;
   endtask

   task automatic checkWord(input string name, input wordT exp, input wordT act);
      if (exp !== act)
      begin
         valueErrors++;
         $display("Error [%s] expected 0x%08h, actual 0x%08h", name, exp, act);
      end
   endtask

   task automatic checkClass(input string name, input instrClassE exp, input instrClassE act);
      if (exp !== act)
      begin
         valueErrors++;
         $display("Error [%s] expected %s (%0d), actual %s (%0d)",
                  name, exp.name(), exp, act.name(), act);
      end
   endtask

   task automatic checkLevel(input string name, input levelT exp, input levelT act);
      if (exp !== act)
      begin
         valueErrors++;
         $display("Error [%s] expected level %0d, actual level %0d", name, exp, act);
      end
   endtask

   // ****************************************
   // bus models
   // ****************************************
   // address beat, then data beat with ack
   task automatic fetchInstr(input addrT pc, input wordT instr);
      instBus.cyc   = 1'b1;
      instBus.stb   = 1'b1;
      instBus.adr   = pc;
      instBus.ack   = 1'b0;
      instBus.datRd = '0;
      nextCycle();
      instBus.adr   = pc + 32'd4;
      instBus.ack   = 1'b1;
      instBus.datRd = instr;
      nextCycle();
      instBus = '0;
   endtask

   // one strobed data cycle, ack optional
   task automatic dataAccess(input logic we, input logic ack);
      dataBus.cyc = 1'b1;
      dataBus.stb = 1'b1;
      dataBus.we  = we;
      dataBus.ack = ack;
      nextCycle();
      dataBus = '0;
   endtask

   task automatic apbWrite(input apbAddrT addr, input wordT data);
      apbReq.psel    = 1'b1;
      apbReq.penable = 1'b0;
      apbReq.pwrite  = 1'b1;
      apbReq.paddr   = addr;
      apbReq.pwdata  = data;
      nextCycle();
      apbReq.penable = 1'b1;
      nextCycle();
      apbReq = '0;
   endtask

   // read data sampled mid access phase
   task automatic apbRead(input apbAddrT addr, output wordT data);
      apbReq.psel    = 1'b1;
      apbReq.penable = 1'b0;
      apbReq.pwrite  = 1'b0;
      apbReq.paddr   = addr;
      apbReq.pwdata  = '0;
      nextCycle();
      apbReq.penable = 1'b1;
      @(negedge CLK);
      data = prdata;
      nextCycle();
      apbReq = '0;
   endtask

   // ****************************************
   // expected record tracking
   // ****************************************
   task automatic fetchAndExpect(input addrT pc, input wordT instr,
                                 input instrClassE cls, input addrT target);
      traceEntryT exp;
      exp            = '0;
      exp.valid      = 1'b1;
      exp.seq        = expSeq;
      exp.pc         = pc;
      exp.target     = target;
      exp.instrClass = cls;
      exp.delaySlot  = expPrevCtrl;
      fetchInstr(pc, instr);
      // dropped records still take a sequence number
      if (expLevel < TRACE_DEPTH)
      begin
         expQ.push_back(exp);
         expLevel++;
      end
      expSeq      = expSeq + seqT'(1);
      expPrevCtrl = (cls == classBranch) || (cls == classJump) || (cls == classJumpReg);
   endtask

   // poll STATUS until the level settles
   task automatic waitForLevel(input string name, input levelT exp);
      wordT status;
      int   tries;
      status = '0;
      for (tries = 0; tries < 10; tries++)
      begin
         apbRead(REG_STATUS, status);
         if (levelT'(status[4:0]) == exp)
         begin
            break;
         end
      end
      checkLevel(name, exp, levelT'(status[4:0]));
   endtask

   // compare head with the oldest expected record, then pop
   task automatic readHeadAndCheck(input string name);
      traceEntryT exp;
      wordT       val;
      if (expQ.size() == 0)
      begin
         otherErrors++;
         $display("[%s] buffer read with no expected record left", name);
      end
      else
      begin
         exp = expQ.pop_front();
         apbRead(REG_PC, val);
         checkWord({name, " pc"}, exp.pc, val);
         apbRead(REG_TARGET, val);
         checkWord({name, " target"}, exp.target, val);
         apbRead(REG_INFO, val);
         checkWord({name, " seq"}, wordT'(exp.seq), wordT'(val[15:0]));
         checkClass({name, " class"}, exp.instrClass, instrClassE'(val[19:16]));
         checkWord({name, " delaySlot"}, wordT'(exp.delaySlot), wordT'(val[24]));
         apbWrite(REG_POP, '0);
         expLevel--;
      end
   endtask

   // ****************************************
   // directed tests
   // ****************************************
   task automatic testResetValues();
      wordT val;
      apbRead(REG_STATUS, val);
      checkWord("resetValues status", 32'h0000_0100, val);
      // remaining offsets sit on a 4-byte stride
      for (int i = 1; i < 8; i++)
      begin
         apbRead(apbAddrT'(4 * i), val);
         checkWord($sformatf("resetValues reg 0x%02h", 4 * i), '0, val);
      end
   endtask

   task automatic testAluFetches();
      logic [31:0] r;
      addrT        pc;
      wordT        instr;
      wordT        val;
      for (int i = 0; i < 3; i++)
      begin
         r     = nextRandom();
         pc    = {r[31:2], 2'b00};
         r     = nextRandom();
         // opcodes 0x08..0x0F, immediate ALU ops and LUI
         instr = {3'b001, r[28:0]};
         fetchAndExpect(pc, instr, classAlu, '0);
      end
      waitForLevel("aluFetches", levelT'(3));
      for (int i = 0; i < 3; i++)
      begin
         readHeadAndCheck("aluFetches");
      end
      apbRead(REG_INSTR_COUNT, val);
      checkWord("aluFetches instrCount", 32'd3, val);
   endtask

   task automatic testBranchDelaySlot();
      addrT        pc;
      logic [15:0] imm;
      addrT        target;
      pc     = 32'h0000_1000;
      imm    = 16'hFFFC;
      // pc+4 plus sign-extended word offset
      target = pc + 32'd4 + ({{16{imm[15]}}, imm} << 2);
      fetchAndExpect(pc, {6'h04, 5'd1, 5'd2, imm}, classBranch, target);
      fetchAndExpect(pc + 32'd4, {6'h0D, 5'd3, 5'd4, 16'h00FF}, classAlu, '0);
      // jr $ra
      fetchAndExpect(32'h0000_2000, {6'h00, 5'd31, 15'd0, 6'h08}, classJumpReg, '0);
      waitForLevel("branchDelaySlot", levelT'(3));
      for (int i = 0; i < 3; i++)
      begin
         readHeadAndCheck("branchDelaySlot");
      end
   endtask

   task automatic testJumpLoadStore();
      addrT        pc;
      logic [25:0] field;
      addrT        target;
      // delay slot opens the next 256MB region
      pc     = 32'hBFFF_FFFC;
      field  = 26'h012_3456;
      // region of pc+4 kept, field shifted to a byte address
      target = ((pc + 32'd4) & 32'hF000_0000) | {4'h0, field, 2'b00};
      fetchAndExpect(pc, {6'h02, field}, classJump, target);
      fetchAndExpect(32'h0000_3000, {6'h23, 5'd29, 5'd8, 16'h0010}, classLoad, '0);
      fetchAndExpect(32'h0000_3004, {6'h2B, 5'd29, 5'd8, 16'h0014}, classStore, '0);
      waitForLevel("jumpLoadStore", levelT'(3));
      for (int i = 0; i < 3; i++)
      begin
         readHeadAndCheck("jumpLoadStore");
      end
   endtask

   task automatic testOverflowFill();
      wordT val;
      for (int i = 0; i < 20; i++)
      begin
         fetchAndExpect(32'h0000_4000 + 32'(4 * i), {6'h09, 5'd1, 5'd1, 16'(i)}, classAlu, '0);
      end
      waitForLevel("overflowFill", levelT'(TRACE_DEPTH));
      // level 16 with overflow set
      apbRead(REG_STATUS, val);
      checkWord("overflowFill status full", 32'h0000_0210, val);
      apbWrite(REG_STATUS, '0);
      apbRead(REG_STATUS, val);
      checkWord("overflowFill status cleared", 32'h0000_0010, val);
      // first record is the head, then drain the rest
      for (int i = 0; i < TRACE_DEPTH; i++)
      begin
         readHeadAndCheck("overflowFill");
      end
      apbRead(REG_STATUS, val);
      checkWord("overflowFill status drained", 32'h0000_0100, val);
   endtask

   task automatic testDataCounters();
      wordT val;
      int   expRd;
      int   expWr;
      logic we;
      logic ack;
      expRd = 0;
      expWr = 0;
      apbRead(REG_INSTR_COUNT, val);
      checkWord("dataCounters instrCount", wordT'(expSeq), val);
      // every third access is left without ack
      for (int i = 0; i < 10; i++)
      begin
         we  = i[0];
         ack = (i % 3) != 2;
         dataAccess(we, ack);
         if (ack && we)
         begin
            expWr++;
         end
         else if (ack)
         begin
            expRd++;
         end
      end
      apbRead(REG_DATA_RD_COUNT, val);
      checkWord("dataCounters rdCount", wordT'(expRd), val);
      apbRead(REG_DATA_WR_COUNT, val);
      checkWord("dataCounters wrCount", wordT'(expWr), val);
      apbWrite(REG_DATA_RD_COUNT, '0);
      apbRead(REG_DATA_RD_COUNT, val);
      checkWord("dataCounters rdCount cleared", '0, val);
      apbRead(REG_DATA_WR_COUNT, val);
      checkWord("dataCounters wrCount kept", wordT'(expWr), val);
      apbWrite(REG_DATA_WR_COUNT, '0);
      apbRead(REG_DATA_WR_COUNT, val);
      checkWord("dataCounters wrCount cleared", '0, val);
      apbWrite(REG_INSTR_COUNT, '0);
      apbRead(REG_INSTR_COUNT, val);
      checkWord("dataCounters instrCount cleared", '0, val);
   endtask

   // ****************************************
   // run control
   // ****************************************
   initial
   begin
      int assertFails;
      instBus = '0;
      dataBus = '0;
      apbReq  = '0;
      wait (RST_SYNC === 1'b1);
      nextCycle();
      testResetValues();
      testAluFetches();
      testBranchDelaySlot();
      testJumpLoadStore();
      testOverflowFill();
      testDataCounters();
      repeat (2) nextCycle();
      assertFails = cpuTraceMonitor_inst.traceFifo_inst.traceMonitor_asserts_inst.failCount;
      $display("Value errors: %0d, other failures: %0d, assertion failures: %0d",
               valueErrors, otherErrors, assertFails);
      if (valueErrors == 0 && otherErrors == 0 && assertFails == 0)
      begin
         $display("Simulation completed successfully");
      end
      else
      begin
         $display("Simulation failed");
      end
      $finish;
   end

   // watchdog
   initial
   begin
      while (cycleCount < CYCLE_LIMIT)
      begin
         @(posedge CLK);
         cycleCount++;
      end
      $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
   end

endmodule

//--- dv/traceMonitor_asserts.sv
// ****************************************
// trace buffer assertions
// bound into the FIFO, checks level, overflow and pop
// ****************************************
`timescale 1ns/1ps

module traceMonitor_asserts
(
   input logic               CLK,
   input logic               RST_SYNC,
   input traceMonPkg::levelT level,
   input logic               overflow,
   input logic               pop
);
   import traceMonPkg::*;

   // failures seen, read by the testbench top
   int failCount = 0;

   // fill level bounded by depth
   property levelBounded;
      @(posedge CLK) disable iff (!RST_SYNC)
         level <= levelT'(TRACE_DEPTH);
   endproperty

   // overflow only rises from a full buffer
   property overflowOnFull;
      @(posedge CLK) disable iff (!RST_SYNC)
         $rose(overflow) |-> ($past(level) == levelT'(TRACE_DEPTH));
   endproperty

   // software never pops an empty buffer
   property popNotEmpty;
      @(posedge CLK) disable iff (!RST_SYNC)
         pop |-> (level != '0);
   endproperty

   levelBoundedA: assert property (levelBounded)
   else
   begin
      failCount++;
      $error("trace buffer level above its depth");
   end

   overflowOnFullA: assert property (overflowOnFull)
   else
   begin
      failCount++;
      $error("overflow rose while the buffer was not full");
   end

   popNotEmptyA: assert property (popNotEmpty)
   else
   begin
      failCount++;
      $error("pop issued while the buffer was empty");
   end

endmodule

//--- dv/tbClockGen.sv
// ****************************************
// testbench clock and reset
// 20 ns clock, reset held low for two cycles
// ****************************************
`timescale 1ns/1ps

module tbClockGen
(
   output logic CLK,
   output logic RST_SYNC
);

   initial
   begin
      CLK = 1'b0;
      forever #10 CLK = ~CLK;
   end

   // release just after the second edge
   initial
   begin
      RST_SYNC = 1'b0;
      repeat (2) @(posedge CLK);
      #1 RST_SYNC = 1'b1;
   end

endmodule

//--- logic/cpuTraceMonitor.sv
// *************************************
// CPU trace monitor top level
// fetch capture -> decode -> trace buffer, APB registers alongside
// *************************************
`timescale 1ns/1ps

module cpuTraceMonitor
(
   input  logic                 CLK,
   input  logic                 RST_SYNC,
   input  traceMonPkg::instBusT instBus,
   input  traceMonPkg::dataBusT dataBus,
   input  traceMonPkg::apbReqT  apbReq,
   output traceMonPkg::wordT    prdata
);
   import traceMonPkg::*;

   fetchRecT   fetchRec;
   traceEntryT traceEntry;
   traceEntryT head;
   levelT      level;
   logic       overflow;
   logic       pop;
   logic       clearOverflow;

   // fetch pairing, record one cycle after ack
   fetchCapture fetchCapture_inst
   (
      .CLK      (CLK),
      .RST_SYNC (RST_SYNC),
      .instBus  (instBus),
      .fetchRec (fetchRec)
   );

   // classify and number
   instrDecode instrDecode_inst
   (
      .CLK        (CLK),
      .RST_SYNC   (RST_SYNC),
      .fetchRec   (fetchRec),
      .traceEntry (traceEntry)
   );

   traceFifo traceFifo_inst
   (
      .CLK           (CLK),
      .RST_SYNC      (RST_SYNC),
      .traceEntry    (traceEntry),
      .pop           (pop),
      .clearOverflow (clearOverflow),
      .head          (head),
      .level         (level),
      .overflow      (overflow)
   );

   // software view, counters see the raw fetch records
   apbRegs apbRegs_inst
   (
      .CLK           (CLK),
      .RST_SYNC      (RST_SYNC),
      .apbReq        (apbReq),
      .prdata        (prdata),
      .dataBus       (dataBus),
      .fetchRec      (fetchRec),
      .head          (head),
      .level         (level),
      .overflow      (overflow),
      .pop           (pop),
      .clearOverflow (clearOverflow)
   );

endmodule

//--- logic/apbRegs.sv
// *************************************
// APB register block
// register decode, activity counters and trace buffer pop
// *************************************
`timescale 1ns/1ps

module apbRegs
(
   input  logic                    CLK,
   input  logic                    RST_SYNC,
   input  traceMonPkg::apbReqT     apbReq,
   output traceMonPkg::wordT       prdata,
   input  traceMonPkg::dataBusT    dataBus,
   input  traceMonPkg::fetchRecT   fetchRec,
   input  traceMonPkg::traceEntryT head,
   input  traceMonPkg::levelT      level,
   input  logic                    overflow,
   output logic                    pop,
   output logic                    clearOverflow
);
   import traceMonPkg::*;

   logic  access;
   logic  wrAccess;
   logic  rdAccess;
   logic  empty;
   logic  dataAck;
   logic  clrInstr;
   logic  clrDataRd;
   logic  clrDataWr;
   countT instrCount;
   countT dataRdCount;
   countT dataWrCount;
   wordT  rdMux;

   // *************************************
   // access decode
   // *************************************
   // zero wait states, the access phase always completes
   assign access   = apbReq.psel && apbReq.penable;
   assign wrAccess = access && apbReq.pwrite;
   assign rdAccess = access && !apbReq.pwrite;

   // write strobes
   assign pop           = wrAccess && (apbReq.paddr == REG_POP);
   assign clearOverflow = wrAccess && (apbReq.paddr == REG_STATUS);
   assign clrInstr      = wrAccess && (apbReq.paddr == REG_INSTR_COUNT);
   assign clrDataRd     = wrAccess && (apbReq.paddr == REG_DATA_RD_COUNT);
   assign clrDataWr     = wrAccess && (apbReq.paddr == REG_DATA_WR_COUNT);

   assign empty = (level == '0);

   // completed data bus transfer
   assign dataAck = dataBus.cyc && dataBus.stb && dataBus.ack;

   // *************************************
   // activity counters
   // *************************************
   // a write clears, and beats a same-cycle event
   always_ff @(posedge CLK)
   begin
      if (!RST_SYNC)
      begin
         instrCount  <= '0;
         dataRdCount <= '0;
         dataWrCount <= '0;
      end
      else
      begin
         if (clrInstr)
         begin
            instrCount <= '0;
         end
         else if (fetchRec.valid)
         begin
            instrCount <= instrCount + countT'(1);
         end
         if (clrDataRd)
         begin
            dataRdCount <= '0;
         end
         else if (dataAck && !dataBus.we)
         begin
            dataRdCount <= dataRdCount + countT'(1);
         end
         if (clrDataWr)
         begin
            dataWrCount <= '0;
         end
         else if (dataAck && dataBus.we)
         begin
            dataWrCount <= dataWrCount + countT'(1);
         end
      end
   end

   // read mux, head fields are already zero while empty
   always_comb
   begin
      case (apbReq.paddr)
         REG_STATUS:
            rdMux = {22'd0, overflow, empty, 3'd0, level};
         REG_PC:
            rdMux = head.pc;
         REG_TARGET:
            rdMux = head.target;
         REG_INFO:
            rdMux = {7'd0, head.delaySlot, 4'd0, head.instrClass, head.seq};
         REG_INSTR_COUNT:
            rdMux = instrCount;
         REG_DATA_RD_COUNT:
            rdMux = dataRdCount;
         REG_DATA_WR_COUNT:
            rdMux = dataWrCount;
         // POP and unmapped offsets read zero
         default:
            rdMux = '0;
      endcase
   end

   assign prdata = rdAccess ? rdMux : '0;

endmodule

//--- logic/traceFifo.sv
// *************************************
// trace record buffer
// circular FIFO, drops on full and flags a sticky overflow
// *************************************
`timescale 1ns/1ps

module traceFifo
(
   input  logic                    CLK,
   input  logic                    RST_SYNC,
   input  traceMonPkg::traceEntryT traceEntry,
   input  logic                    pop,
   input  logic                    clearOverflow,
   output traceMonPkg::traceEntryT head,
   output traceMonPkg::levelT      level,
   output logic                    overflow
);
   import traceMonPkg::*;

   traceEntryT mem [TRACE_DEPTH];
   ptrT        wrPtr;
   ptrT        rdPtr;
   logic       full;
   logic       empty;
   logic       push;
   logic       drop;
   logic       doPop;

   assign full  = (level == levelT'(TRACE_DEPTH));
   assign empty = (level == '0);
   // the core cannot be stalled, so a full buffer loses the record
   assign push  = traceEntry.valid && !full;
   assign drop  = traceEntry.valid && full;
   // pop on empty is ignored
   assign doPop = pop && !empty;

   // entry storage
   always_ff @(posedge CLK)
   begin
      if (push)
      begin
         mem[wrPtr] <= traceEntry;
      end
   end

   // *************************************
   // pointers and fill level
   // *************************************
   always_ff @(posedge CLK)
   begin
      if (!RST_SYNC)
      begin
         wrPtr <= '0;
         rdPtr <= '0;
         level <= '0;
      end
      else
      begin
         // pointers wrap at the power-of-two depth
         if (push)
         begin
            wrPtr <= wrPtr + ptrT'(1);
         end
         if (doPop)
         begin
            rdPtr <= rdPtr + ptrT'(1);
         end
         if (push && !doPop)
         begin
            level <= level + levelT'(1);
         end
         else if (doPop && !push)
         begin
            level <= level - levelT'(1);
         end
      end
   end

   // sticky overflow, a new drop wins over a clear
   always_ff @(posedge CLK)
   begin
      if (!RST_SYNC)
      begin
         overflow <= 1'b0;
      end
      else if (drop)
      begin
         overflow <= 1'b1;
      end
      else if (clearOverflow)
      begin
         overflow <= 1'b0;
      end
   end

   // oldest entry, all zero while empty
   assign head = empty ? '0 : mem[rdPtr];

endmodule

//--- logic/instrDecode.sv
// *************************************
// instruction decode stage
// classifies each fetch, computes branch/jump targets, numbers records
// *************************************
`timescale 1ns/1ps

module instrDecode
(
   input  logic                    CLK,
   input  logic                    RST_SYNC,
   input  traceMonPkg::fetchRecT   fetchRec,
   output traceMonPkg::traceEntryT traceEntry
);
   import traceMonPkg::*;

   logic [5:0]  opcode;
   logic [5:0]  funct;
   logic [4:0]  rt;
   logic [15:0] immed;
   logic [25:0] jumpField;
   addrT        pcPlus4;
   addrT        branchOffset;
   addrT        target;
   instrClassE  instrClass;
   logic        isCtrl;
   seqT         seq;
   logic        prevCtrl;

   // field extraction
   assign opcode    = fetchRec.instr[OPC_HI:OPC_LO];
   assign funct     = fetchRec.instr[FUNCT_HI:FUNCT_LO];
   assign rt        = fetchRec.instr[RT_HI:RT_LO];
   assign immed     = fetchRec.instr[IMMED_HI:IMMED_LO];
   assign jumpField = fetchRec.instr[TARGET_HI:TARGET_LO];

   // *************************************
   // classification
   // *************************************
   always_comb
   begin
      instrClass = classOther;
      case (opcode) inside
         OPC_SPECIAL:
         begin
            case (funct) inside
               FUNCT_SLL, FUNCT_SRL, FUNCT_SRA,
               FUNCT_SLLV, FUNCT_SRLV, FUNCT_SRAV:
                  instrClass = classShift;
               FUNCT_JR, FUNCT_JALR:
                  instrClass = classJumpReg;
               FUNCT_SYSCALL, FUNCT_BREAK:
                  instrClass = classSystem;
               // HI/LO moves, then mult/div
               [FUNCT_MFHI:FUNCT_MTLO], [FUNCT_MULT:FUNCT_DIVU]:
                  instrClass = classMulDiv;
               [FUNCT_ADD:FUNCT_NOR], [FUNCT_SLT:FUNCT_SLTU]:
                  instrClass = classAlu;
               default:
                  instrClass = classOther;
            endcase
         end
         OPC_REGIMM:
         begin
            // only the four defined rt codes are branches
            case (rt)
               REGIMM_BLTZ, REGIMM_BGEZ, REGIMM_BLTZAL, REGIMM_BGEZAL:
                  instrClass = classBranch;
               default:
                  instrClass = classOther;
            endcase
         end
         OPC_J, OPC_JAL:
            instrClass = classJump;
         OPC_BEQ, OPC_BNE, OPC_BLEZ, OPC_BGTZ:
            instrClass = classBranch;
         // immediate ALU block includes LUI
         [OPC_ADDI:OPC_LUI]:
            instrClass = classAlu;
         [OPC_COP0:OPC_COP3]:
            instrClass = classSystem;
         [OPC_LB:OPC_LWR]:
            instrClass = classLoad;
         [OPC_SB:OPC_SW], OPC_SWR:
            instrClass = classStore;
         default:
            instrClass = classOther;
      endcase
   end

   // *************************************
   // target computation
   // *************************************
   assign pcPlus4      = fetchRec.pc + 32'd4;
   // word offset, sign extended
   assign branchOffset = {{14{immed[15]}}, immed, 2'b00};

   always_comb
   begin
      case (instrClass)
         classBranch:
            target = pcPlus4 + branchOffset;
         // stays in the 256MB region of the delay slot
         classJump:
            target = {pcPlus4[31:28], jumpField, 2'b00};
         default:
            target = '0;
      endcase
   end

   // next record sits in a delay slot
   assign isCtrl = (instrClass == classBranch) || (instrClass == classJump) ||
                   (instrClass == classJumpReg);

   // sequence and delay-slot tracking, one step per record
   always_ff @(posedge CLK)
   begin
      if (!RST_SYNC)
      begin
         traceEntry.valid <= 1'b0;
         seq              <= '0;
         prevCtrl         <= 1'b0;
      end
      else
      begin
         traceEntry.valid <= fetchRec.valid;
         if (fetchRec.valid)
         begin
            seq      <= seq + seqT'(1);
            prevCtrl <= isCtrl;
         end
      end
   end

   // entry payload
   always_ff @(posedge CLK)
   begin
      if (fetchRec.valid)
      begin
         traceEntry.seq        <= seq;
         traceEntry.pc         <= fetchRec.pc;
         traceEntry.target     <= target;
         traceEntry.instrClass <= instrClass;
         traceEntry.delaySlot  <= prevCtrl;
      end
   end

endmodule

//--- logic/fetchCapture.sv
// *************************************
// instruction fetch capture
// pairs each address beat with the read data acked a cycle later
// *************************************
`timescale 1ns/1ps

module fetchCapture
(
   input  logic                  CLK,
   input  logic                  RST_SYNC,
   input  traceMonPkg::instBusT  instBus,
   output traceMonPkg::fetchRecT fetchRec
);
   import traceMonPkg::*;

   addrT pendAddr;
   logic addrBeat;
   logic dataBeat;

   // every strobed cycle carries an address
   assign addrBeat = instBus.cyc && instBus.stb;
   // ack returns data for the previous address
   assign dataBeat = addrBeat && instBus.ack;

   // pending address, overwritten on each address beat
   // read before the update, so a data beat that also issues
   // the next address still pairs with the older one
   always_ff @(posedge CLK)
   begin
      if (addrBeat)
      begin
         pendAddr <= instBus.adr;
      end
   end

   // one-cycle valid pulse after the ack
   always_ff @(posedge CLK)
   begin
      if (!RST_SYNC)
      begin
         fetchRec.valid <= 1'b0;
      end
      else
      begin
         fetchRec.valid <= dataBeat;
      end
   end

   // record payload
   always_ff @(posedge CLK)
   begin
      if (dataBeat)
      begin
         fetchRec.pc    <= pendAddr;
         fetchRec.instr <= instBus.datRd;
      end
   end

endmodule

//--- logic/traceMonPkg.sv
// *************************************
// trace monitor shared definitions
// widths, opcode fields, record structs and the APB register map
// *************************************

package traceMonPkg;

   // *************************************
   // sizes and vector types
   // *************************************
   localparam int TRACE_DEPTH = 16;
   localparam int TRACE_PTR_W = $clog2(TRACE_DEPTH);

   typedef logic [31:0] addrT;
   typedef logic [31:0] wordT;
   // both counter kinds wrap silently
   typedef logic [15:0] seqT;
   typedef logic [31:0] countT;
   // one extra bit so a full buffer reads 16
   typedef logic [TRACE_PTR_W:0] levelT;
   typedef logic [TRACE_PTR_W-1:0] ptrT;
   typedef logic [7:0] apbAddrT;

   // instruction field positions
   localparam int OPC_HI = 31;
   localparam int OPC_LO = 26;
   localparam int RT_HI = 20;
   localparam int RT_LO = 16;
   localparam int IMMED_HI = 15;
   localparam int IMMED_LO = 0;
   localparam int TARGET_HI = 25;
   localparam int TARGET_LO = 0;
   localparam int FUNCT_HI = 5;
   localparam int FUNCT_LO = 0;

   // *************************************
   // primary opcodes
   // *************************************
   localparam logic [5:0] OPC_SPECIAL = 6'h00;
   localparam logic [5:0] OPC_REGIMM = 6'h01;
   localparam logic [5:0] OPC_J = 6'h02;
   localparam logic [5:0] OPC_JAL = 6'h03;
   localparam logic [5:0] OPC_BEQ = 6'h04;
   localparam logic [5:0] OPC_BNE = 6'h05;
   localparam logic [5:0] OPC_BLEZ = 6'h06;
   localparam logic [5:0] OPC_BGTZ = 6'h07;
   // immediate ALU ops run ADDI up to LUI
   localparam logic [5:0] OPC_ADDI = 6'h08;
   localparam logic [5:0] OPC_LUI = 6'h0F;
   localparam logic [5:0] OPC_COP0 = 6'h10;
   localparam logic [5:0] OPC_COP3 = 6'h13;
   // loads are a dense block LB..LWR
   localparam logic [5:0] OPC_LB = 6'h20;
   localparam logic [5:0] OPC_LWR = 6'h26;
   // stores SB..SW, then SWR on its own
   localparam logic [5:0] OPC_SB = 6'h28;
   localparam logic [5:0] OPC_SW = 6'h2B;
   localparam logic [5:0] OPC_SWR = 6'h2E;

   // SPECIAL function field
   localparam logic [5:0] FUNCT_SLL = 6'h00;
   localparam logic [5:0] FUNCT_SRL = 6'h02;
   localparam logic [5:0] FUNCT_SRA = 6'h03;
   localparam logic [5:0] FUNCT_SLLV = 6'h04;
   localparam logic [5:0] FUNCT_SRLV = 6'h06;
   localparam logic [5:0] FUNCT_SRAV = 6'h07;
   localparam logic [5:0] FUNCT_JR = 6'h08;
   localparam logic [5:0] FUNCT_JALR = 6'h09;
   localparam logic [5:0] FUNCT_SYSCALL = 6'h0C;
   localparam logic [5:0] FUNCT_BREAK = 6'h0D;
   localparam logic [5:0] FUNCT_MFHI = 6'h10;
   localparam logic [5:0] FUNCT_MTLO = 6'h13;
   localparam logic [5:0] FUNCT_MULT = 6'h18;
   localparam logic [5:0] FUNCT_DIVU = 6'h1B;
   localparam logic [5:0] FUNCT_ADD = 6'h20;
   localparam logic [5:0] FUNCT_NOR = 6'h27;
   localparam logic [5:0] FUNCT_SLT = 6'h2A;
   localparam logic [5:0] FUNCT_SLTU = 6'h2B;

   // REGIMM branches, selected by rt
   localparam logic [4:0] REGIMM_BLTZ = 5'h00;
   localparam logic [4:0] REGIMM_BGEZ = 5'h01;
   localparam logic [4:0] REGIMM_BLTZAL = 5'h10;
   localparam logic [4:0] REGIMM_BGEZAL = 5'h11;

   // *************************************
   // APB register map
   // *************************************
   localparam apbAddrT REG_STATUS = 8'h00;
   localparam apbAddrT REG_PC = 8'h04;
   localparam apbAddrT REG_TARGET = 8'h08;
   localparam apbAddrT REG_INFO = 8'h0C;
   localparam apbAddrT REG_POP = 8'h10;
   localparam apbAddrT REG_INSTR_COUNT = 8'h14;
   localparam apbAddrT REG_DATA_RD_COUNT = 8'h18;
   localparam apbAddrT REG_DATA_WR_COUNT = 8'h1C;

   typedef enum logic [3:0] {
      classAlu,
      classShift,
      classMulDiv,
      classBranch,
      classJump,
      classJumpReg,
      classLoad,
      classStore,
      classSystem,
      classOther
   } instrClassE;

   // *************************************
   // bus and record structs
   // *************************************
   typedef struct packed {
      logic cyc;
      logic stb;
      addrT adr;
      logic ack;
      wordT datRd;
   } instBusT;

   typedef struct packed {
      logic cyc;
      logic stb;
      logic we;
      logic ack;
   } dataBusT;

   typedef struct packed {
      logic valid;
      addrT pc;
      wordT instr;
   } fetchRecT;

   // valid marks a new record from decode, and a non-empty head
   typedef struct packed {
      logic valid;
      seqT seq;
      addrT pc;
      addrT target;
      instrClassE instrClass;
      logic delaySlot;
   } traceEntryT;

   typedef struct packed {
      logic psel;
      logic penable;
      logic pwrite;
      apbAddrT paddr;
      wordT pwdata;
   } apbReqT;

endpackage
